//--- jpeg_front_consts.svh
`ifndef JPEG_FRONT_CONSTS_SVH
`define JPEG_FRONT_CONSTS_SVH

// frame geometry, both sizes even
`define SENSOR_X_SIZE 16
`define SENSOR_Y_SIZE 8

// one colour component
`define PIXEL_DW 8
`define PIX_MAX 255

// Q8 fixed point colour conversion
`define FRAC_BITS 8
`define ROUND_Q8 128
`define CHROMA_OFFSET 128

// half lsb for the divide by four of the 2x2 block
`define CHROMA_RND 2

`endif

//--- jpeg_front_pkg.sv
`include "jpeg_front_consts.svh"

package jpeg_front_pkg;

    // one unsigned colour component
    typedef logic [`PIXEL_DW-1:0] pixel_t;

    // sum of two components, one bit of headroom
    typedef logic [`PIXEL_DW:0] chroma_sum_t;

    // per component valid
    // bit 0 is Y, bit 1 is Cb, bit 2 is Cr
    typedef logic [2:0] comp_valid_t;

endpackage

//--- dp_ram.sv
`timescale 1ns/10ps

module dp_ram import jpeg_front_pkg::*; #(
    parameter int DW    = 2 * $bits(chroma_sum_t),
    parameter int DEPTH = 8
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] wa,
    input  logic [$clog2(DEPTH)-1:0] ra,
    input  logic [DW-1:0]            wd,
    input  logic                     we,
    input  logic                     re,
    output logic [DW-1:0]            rd
);

    logic [DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
    end

    // registered read, output holds while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rd <= mem[ra];
        end
    end

    // write address comes from the client counters
    a_wa_in_range: assert property (
        @(posedge clk) we |-> (int'(wa) < DEPTH)
    ) else $error("dp_ram write address %0d out of range", wa);

endmodule

//--- rgb2yuv.sv
`timescale 1ns/10ps
`include "jpeg_front_consts.svh"

module rgb2yuv import jpeg_front_pkg::*; (
    input  logic   clk,
    input  logic   resetn,
    input  pixel_t r_in,
    input  pixel_t g_in,
    input  pixel_t b_in,
    input  logic   in_valid,
    input  logic   frame_valid_in,
    input  logic   line_valid_in,
    input  logic   hold,
    output logic   in_hold,
    output pixel_t y,
    output pixel_t cb,
    output pixel_t cr,
    output logic   out_valid,
    output logic   frame_valid_out,
    output logic   line_valid_out
);

    localparam int SW = 18; // weighted sums, signed

    // Q8 weights
    localparam int signed C_YR = 77;
    localparam int signed C_YG = 150;
    localparam int signed C_YB = 29;
    localparam int signed C_BR = 43;
    localparam int signed C_BG = 85;
    localparam int signed C_BB = 128;
    localparam int signed C_RR = 128;
    localparam int signed C_RG = 107;
    localparam int signed C_RB = 21;

    function automatic pixel_t clamp_pix(input logic signed [SW-1:0] v);
        if (v < 0) begin
            return '0;
        end else if (v > `PIX_MAX) begin
            return pixel_t'(`PIX_MAX);
        end
        return pixel_t'(v);
    endfunction

    logic                         en;
    logic signed [`PIXEL_DW:0]    r_s, g_s, b_s;
    logic signed [SW-1:0]         y_sum_d, cb_sum_d, cr_sum_d;
    logic signed [SW-1:0]         s1_y_sum, s1_cb_sum, s1_cr_sum;
    logic                         s1_valid, s1_fv, s1_lv;
    logic signed [SW-1:0]         y_sh, cb_sh, cr_sh;

    assign en      = !hold;
    assign in_hold = hold; // hold goes straight upstream

    // zero extended so the products stay signed
    assign r_s = {1'b0, r_in};
    assign g_s = {1'b0, g_in};
    assign b_s = {1'b0, b_in};

    assign y_sum_d  = SW'(C_YR * r_s + C_YG * g_s + C_YB * b_s);
    assign cb_sum_d = SW'(C_BB * b_s - C_BR * r_s - C_BG * g_s);
    assign cr_sum_d = SW'(C_RR * r_s - C_RG * g_s - C_RB * b_s);

    // stage one, weighted sums
    always_ff @(posedge clk) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            s1_fv    <= 1'b0;
            s1_lv    <= 1'b0;
        end else if (en) begin
            s1_valid <= in_valid;
            s1_fv    <= frame_valid_in;
            s1_lv    <= line_valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (en && in_valid) begin
            s1_y_sum  <= y_sum_d;
            s1_cb_sum <= cb_sum_d;
            s1_cr_sum <= cr_sum_d;
        end
    end

    // round and scale back, arithmetic shift keeps the sign
    assign y_sh  = SW'((s1_y_sum + `ROUND_Q8) >>> `FRAC_BITS);
    assign cb_sh = SW'(((s1_cb_sum + `ROUND_Q8) >>> `FRAC_BITS) + `CHROMA_OFFSET);
    assign cr_sh = SW'(((s1_cr_sum + `ROUND_Q8) >>> `FRAC_BITS) + `CHROMA_OFFSET);

    // stage two, clamped components
    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid       <= 1'b0;
            frame_valid_out <= 1'b0;
            line_valid_out  <= 1'b0;
        end else if (en) begin
            out_valid       <= s1_valid;
            frame_valid_out <= s1_fv;
            line_valid_out  <= s1_lv;
        end
    end

    always_ff @(posedge clk) begin
        if (en && s1_valid) begin
            y  <= clamp_pix(y_sh);
            cb <= clamp_pix(cb_sh);
            cr <= clamp_pix(cr_sh);
        end
    end

    // a held output beat must not change under the consumer
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        (hold && out_valid) |=> ($stable(y) && $stable(cb) && $stable(cr))
    ) else $error("rgb2yuv output changed under hold");

endmodule

//--- subsample.sv
`timescale 1ns/10ps
`include "jpeg_front_consts.svh"

module subsample import jpeg_front_pkg::*; (
    input  logic                              clk,
    input  logic                              resetn,
    input  pixel_t                            y_in,
    input  pixel_t                            cb_in,
    input  pixel_t                            cr_in,
    input  logic                              in_valid,
    input  logic                              frame_valid_in,
    input  logic                              line_valid_in,
    input  logic                              out_hold,
    output logic                              in_hold,
    output pixel_t                            y_out,
    output pixel_t                            cb_out,
    output pixel_t                            cr_out,
    output comp_valid_t                       out_valid,
    output logic                              eof_out,
    output logic [$clog2(`SENSOR_X_SIZE)-1:0] out_pixel_count,
    output logic [$clog2(`SENSOR_Y_SIZE)-1:0] out_line_count
);

    localparam int XW       = $clog2(`SENSOR_X_SIZE);
    localparam int YW       = $clog2(`SENSOR_Y_SIZE);
    localparam int LB_DEPTH = `SENSOR_X_SIZE / 2;
    localparam int LB_DW    = 2 * $bits(chroma_sum_t);

    logic              en, acc;
    logic              fv_q, lv_q;
    logic              eof, eol;
    logic [XW-1:0]     pixel_count;
    logic [YW-1:0]     line_count;
    logic              odd_pix, odd_line;
    logic              lb_we, lb_re;
    logic [LB_DW-1:0]  lb_rd;
    chroma_sum_t       lb_cb, lb_cr;
    pixel_t            cb_even, cr_even;
    chroma_sum_t       cb_pair, cr_pair;
    logic [`PIXEL_DW+1:0] cb_sum4, cr_sum4;

    assign in_hold = out_hold;
    assign en      = !out_hold;
    assign acc     = en && in_valid && line_valid_in; // pixel taken this cycle

    assign odd_pix  = pixel_count[0];
    assign odd_line = line_count[0];

    // framing edges, frozen with the rest under hold
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fv_q <= 1'b0;
            lv_q <= 1'b0;
        end else if (en) begin
            fv_q <= frame_valid_in;
            lv_q <= line_valid_in;
        end
    end

    assign eof = fv_q && !frame_valid_in;
    assign eol = lv_q && !line_valid_in;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pixel_count <= '0;
            line_count  <= '0;
        end else if (en) begin
            if (eof) begin
                pixel_count <= '0;
                line_count  <= '0;
            end else if (eol) begin
                pixel_count <= '0;
                line_count  <= line_count + 1'b1;
            end else if (acc) begin
                pixel_count <= pixel_count + 1'b1;
            end
        end
    end

    // even pixel chroma, kept to form the pair sum
    always_ff @(posedge clk) begin
        if (acc && !odd_pix) begin
            cb_even <= cb_in;
            cr_even <= cr_in;
        end
    end

    assign cb_pair = cb_even + cb_in;
    assign cr_pair = cr_even + cr_in;

    // even line writes at the odd pixel, odd line reads at the even pixel
    assign lb_we = acc && !odd_line && odd_pix;
    assign lb_re = acc && odd_line && !odd_pix;

    dp_ram #(
        .DW    (LB_DW),
        .DEPTH (LB_DEPTH)
    ) line_buf (
        .clk (clk),
        .wa  (pixel_count[XW-1:1]),
        .ra  (pixel_count[XW-1:1]),
        .wd  ({cb_pair, cr_pair}),
        .we  (lb_we),
        .re  (lb_re),
        .rd  (lb_rd)
    );

    assign {lb_cb, lb_cr} = lb_rd;

    // 2x2 block, rounded divide by four
    assign cb_sum4 = lb_cb + cb_pair + `CHROMA_RND;
    assign cr_sum4 = lb_cr + cr_pair + `CHROMA_RND;

    always_ff @(posedge clk) begin
        if (acc) begin
            y_out <= y_in; // luma at full rate
        end
        if (acc && odd_line && odd_pix) begin
            cb_out <= cb_sum4[`PIXEL_DW+1:2];
            cr_out <= cr_sum4[`PIXEL_DW+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid       <= '0;
            eof_out         <= 1'b0;
            out_pixel_count <= '0;
            out_line_count  <= '0;
        end else if (en) begin
            out_valid[0] <= acc;
            out_valid[1] <= acc && odd_line && odd_pix;
            out_valid[2] <= acc && odd_line && odd_pix;
            eof_out      <= eof;
            if (acc) begin
                out_pixel_count <= pixel_count;
                out_line_count  <= line_count;
            end
        end
    end

    // emitted position must agree with the chroma valids
    a_no_chroma_even: assert property (
        @(posedge clk) disable iff (!resetn)
        out_valid[1] |-> out_line_count[0]
    ) else $error("chroma valid on an even line");

    a_cb_cr_paired: assert property (
        @(posedge clk) disable iff (!resetn)
        (out_valid[1] || out_valid[2]) |-> ((out_valid == 3'b111) && out_pixel_count[0])
    ) else $error("cb and cr valids split or off the odd pixel");

endmodule

//--- jpeg_front.sv
`timescale 1ns/10ps
`include "jpeg_front_consts.svh"

module jpeg_front import jpeg_front_pkg::*; (
    input  logic                              clk,
    input  logic                              resetn,
    input  pixel_t                            r_in,
    input  pixel_t                            g_in,
    input  pixel_t                            b_in,
    input  logic                              pixel_in_valid,
    input  logic                              frame_valid_in,
    input  logic                              line_valid_in,
    input  logic                              yuv_out_hold,
    output logic                              pixel_in_hold,
    output pixel_t                            y_out,
    output pixel_t                            cb_out,
    output pixel_t                            cr_out,
    output comp_valid_t                       yuv_out_valid,
    output logic                              eof_out,
    output logic [$clog2(`SENSOR_X_SIZE)-1:0] out_pixel_count,
    output logic [$clog2(`SENSOR_Y_SIZE)-1:0] out_line_count
);

    pixel_t ycc_y, ycc_cb, ycc_cr;
    logic   ycc_valid;
    logic   ycc_fv, ycc_lv;
    logic   ycc_hold; // subsample back to converter

    rgb2yuv rgb2yuv_i (
        .clk             (clk),
        .resetn          (resetn),
        .r_in            (r_in),
        .g_in            (g_in),
        .b_in            (b_in),
        .in_valid        (pixel_in_valid),
        .frame_valid_in  (frame_valid_in),
        .line_valid_in   (line_valid_in),
        .hold            (ycc_hold),
        .in_hold         (pixel_in_hold),
        .y               (ycc_y),
        .cb              (ycc_cb),
        .cr              (ycc_cr),
        .out_valid       (ycc_valid),
        .frame_valid_out (ycc_fv),
        .line_valid_out  (ycc_lv)
    );

    subsample subsample_i (
        .clk             (clk),
        .resetn          (resetn),
        .y_in            (ycc_y),
        .cb_in           (ycc_cb),
        .cr_in           (ycc_cr),
        .in_valid        (ycc_valid),
        .frame_valid_in  (ycc_fv),
        .line_valid_in   (ycc_lv),
        .out_hold        (yuv_out_hold),
        .in_hold         (ycc_hold),
        .y_out           (y_out),
        .cb_out          (cb_out),
        .cr_out          (cr_out),
        .out_valid       (yuv_out_valid),
        .eof_out         (eof_out),
        .out_pixel_count (out_pixel_count),
        .out_line_count  (out_line_count)
    );

endmodule

//--- tb_jpeg_front.sv
`timescale 1ns/10ps
`include "jpeg_front_consts.svh"

module tb_jpeg_front import jpeg_front_pkg::*; ();

    localparam int XS = `SENSOR_X_SIZE;
    localparam int YS = `SENSOR_Y_SIZE;
    localparam int XW = $clog2(XS);
    localparam int YW = $clog2(YS);
    localparam int STALL_LIMIT = 200;   // cycles one slot may sit under hold
    localparam int DRAIN_LIMIT = 3000;  // cycles for a frame to flush out

    typedef struct packed {
        logic [YW-1:0] line;
        logic [XW-1:0] pix;
        comp_valid_t   vld;
        pixel_t        y;
        pixel_t        cb;
        pixel_t        cr;
    } beat_t;

    logic          clk = 1'b0;
    logic          resetn;
    pixel_t        r_in, g_in, b_in;
    logic          pixel_in_valid, frame_valid_in, line_valid_in;
    logic          yuv_out_hold;
    logic          pixel_in_hold;
    pixel_t        y_out, cb_out, cr_out;
    comp_valid_t   yuv_out_valid;
    logic          eof_out;
    logic [XW-1:0] out_pixel_count;
    logic [YW-1:0] out_line_count;

    pixel_t frame_r [YS][XS];
    pixel_t frame_g [YS][XS];
    pixel_t frame_b [YS][XS];

    integer seed;
    beat_t  exp_q [$];
    int     eof_count = 0;
    int     frames_sent = 0;
    int     cycle = 0;
    int     first_in = -1;
    int     first_out = -1;
    logic   stress = 1'b0; // random hold and input gaps

    always #5 clk = ~clk;

    jpeg_front jpeg_front_i (
        .clk             (clk),
        .resetn          (resetn),
        .r_in            (r_in),
        .g_in            (g_in),
        .b_in            (b_in),
        .pixel_in_valid  (pixel_in_valid),
        .frame_valid_in  (frame_valid_in),
        .line_valid_in   (line_valid_in),
        .yuv_out_hold    (yuv_out_hold),
        .pixel_in_hold   (pixel_in_hold),
        .y_out           (y_out),
        .cb_out          (cb_out),
        .cr_out          (cr_out),
        .yuv_out_valid   (yuv_out_valid),
        .eof_out         (eof_out),
        .out_pixel_count (out_pixel_count),
        .out_line_count  (out_line_count)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    function automatic pixel_t clip_to_pixel(input int v);
        if (v < 0) begin
            return '0;
        end else if (v > 255) begin
            return 8'hff;
        end
        return pixel_t'(v);
    endfunction

    // returns {y, cb, cr}
    function automatic logic [23:0] rgb_to_ycc(input int r, input int g, input int b);
        int y, cb, cr;
        y  = (77 * r + 150 * g + 29 * b + 128) >>> 8;
        cb = ((128 * b - 43 * r - 85 * g + 128) >>> 8) + 128;
        cr = ((128 * r - 107 * g - 21 * b + 128) >>> 8) + 128;
        return {clip_to_pixel(y), clip_to_pixel(cb), clip_to_pixel(cr)};
    endfunction

    // comp 1 is cb, 2 is cr, block at bx, by in 2x2 units
    function automatic pixel_t chroma_avg(input int bx, input int by, input int comp);
        int          sum;
        logic [23:0] ycc;
        sum = 0;
        for (int dy = 0; dy < 2; dy++) begin
            for (int dx = 0; dx < 2; dx++) begin
                ycc = rgb_to_ycc(frame_r[2*by+dy][2*bx+dx], frame_g[2*by+dy][2*bx+dx],
                                 frame_b[2*by+dy][2*bx+dx]);
                sum += (comp == 1) ? int'(ycc[15:8]) : int'(ycc[7:0]);
            end
        end
        return pixel_t'((sum + 2) >> 2);
    endfunction

    task automatic fill_frame(input int mode);
        for (int yy = 0; yy < YS; yy++) begin
            for (int xx = 0; xx < XS; xx++) begin
                if (mode == 0) begin
                    frame_r[yy][xx] = pixel_t'($random(seed));
                    frame_g[yy][xx] = pixel_t'($random(seed));
                    frame_b[yy][xx] = pixel_t'($random(seed));
                end else begin
                    case ((xx + 3 * yy) % 4) // red, blue, white, black
                        0: {frame_r[yy][xx], frame_g[yy][xx], frame_b[yy][xx]} = 24'hff0000;
                        1: {frame_r[yy][xx], frame_g[yy][xx], frame_b[yy][xx]} = 24'h0000ff;
                        2: {frame_r[yy][xx], frame_g[yy][xx], frame_b[yy][xx]} = 24'hffffff;
                        default: {frame_r[yy][xx], frame_g[yy][xx], frame_b[yy][xx]} = 24'h0;
                    endcase
                end
            end
        end
    endtask

    task automatic push_expected();
        beat_t       e;
        logic [23:0] ycc;
        for (int yy = 0; yy < YS; yy++) begin
            for (int xx = 0; xx < XS; xx++) begin
                ycc    = rgb_to_ycc(frame_r[yy][xx], frame_g[yy][xx], frame_b[yy][xx]);
                e.line = YW'(yy);
                e.pix  = XW'(xx);
                e.y    = ycc[23:16];
                if ((yy % 2 == 1) && (xx % 2 == 1)) begin
                    e.vld = 3'b111; // block average on the odd pixel of an odd line
                    e.cb  = chroma_avg(xx / 2, yy / 2, 1);
                    e.cr  = chroma_avg(xx / 2, yy / 2, 2);
                end else begin
                    e.vld = 3'b001;
                    e.cb  = '0;
                    e.cr  = '0;
                end
                exp_q.push_back(e);
            end
        end
    endtask

    // one input slot, held until it is taken
    task automatic drive_slot(input logic fv, input logic lv, input logic v,
                              input pixel_t r, input pixel_t g, input pixel_t b);
        int stalls;
        stalls = 0;
        frame_valid_in <= fv;
        line_valid_in  <= lv;
        pixel_in_valid <= v;
        r_in           <= r;
        g_in           <= g;
        b_in           <= b;
        yuv_out_hold   <= stress && (($random(seed) & 3) == 0);
        @(posedge clk);
        while (pixel_in_hold) begin
            stalls++;
            if (stalls > STALL_LIMIT) begin
                fail_run("Timed out waiting for pixel_in_hold to release an input slot");
            end else begin
                yuv_out_hold <= stress && (($random(seed) & 3) == 0);
                @(posedge clk);
            end
        end
    endtask

    task automatic send_frame();
        drive_slot(1'b1, 1'b0, 1'b0, '0, '0, '0); // frame start, no line yet
        for (int yy = 0; yy < YS; yy++) begin
            for (int xx = 0; xx < XS; xx++) begin
                if (stress && (($random(seed) & 3) == 0)) begin
                    drive_slot(1'b1, 1'b1, 1'b0, '0, '0, '0); // gap inside the line
                end
                drive_slot(1'b1, 1'b1, 1'b1, frame_r[yy][xx], frame_g[yy][xx], frame_b[yy][xx]);
            end
            drive_slot(1'b1, 1'b0, 1'b0, '0, '0, '0); // line blanking
        end
        drive_slot(1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_slot(1'b0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic wait_frame_done();
        int waited;
        waited = 0;
        yuv_out_hold <= 1'b0;
        while (exp_q.size() != 0 || eof_count != frames_sent) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                fail_run($sformatf("Timed out waiting for frame %0d to drain", frames_sent));
            end else begin
                @(posedge clk);
            end
        end
        repeat (10) @(posedge clk);
        check_value("eof_out pulse count", eof_count, frames_sent);
    endtask

    task automatic run_frame(input int mode, input logic with_stress);
        fill_frame(mode);
        push_expected();
        stress = with_stress;
        send_frame();
        frames_sent++;
        wait_frame_done();
    endtask

    // output monitor, a beat moves on valid with hold low
    always @(posedge clk) begin
        beat_t exp_beat;
        cycle = cycle + 1;
        if (resetn) begin
            check_value("pixel_in_hold", pixel_in_hold, yuv_out_hold);
            if (first_in < 0 && pixel_in_valid && line_valid_in && !pixel_in_hold) begin
                first_in = cycle;
            end
            if (yuv_out_valid != 3'b000 && !yuv_out_hold) begin
                if (first_out < 0) begin
                    first_out = cycle;
                end
                if (exp_q.size() == 0) begin
                    fail_run("Output beat arrived with no pixel left to match it");
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_value("yuv_out_valid", yuv_out_valid, exp_beat.vld);
                    check_value("y_out", y_out, exp_beat.y);
                    check_value("out_pixel_count", out_pixel_count, exp_beat.pix);
                    check_value("out_line_count", out_line_count, exp_beat.line);
                    if (exp_beat.vld[1]) begin
                        check_value("cb_out", cb_out, exp_beat.cb);
                        check_value("cr_out", cr_out, exp_beat.cr);
                    end
                end
            end
            if (eof_out && !yuv_out_hold) begin
                eof_count = eof_count + 1;
                check_value("beats missing at eof_out", exp_q.size(), 0);
            end
        end
    end

    initial begin
        seed           = 32'ha290aab9;
        resetn         = 1'b0;
        r_in           = '0;
        g_in           = '0;
        b_in           = '0;
        pixel_in_valid = 1'b0;
        frame_valid_in = 1'b0;
        line_valid_in  = 1'b0;
        yuv_out_hold   = 1'b0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        run_frame(0, 1'b0);
        check_value("first y_out latency", first_out - first_in, 3);
        run_frame(0, 1'b0); // counters must restart at zero
        run_frame(1, 1'b0); // saturated colours hit the clamps
        run_frame(0, 1'b1);
        run_frame(1, 1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

//--- jpeg_front.f
+incdir+.
jpeg_front_pkg.sv
dp_ram.sv
rgb2yuv.sv
subsample.sv
jpeg_front.sv
tb_jpeg_front.sv
